// ==== src.f ====
hdl/aes_ctrl_pkg.sv
hdl/aes_sp2v_chk.sv
hdl/aes_ctrl_rail.sv
hdl/aes_rail_combine.sv
hdl/aes_ciph_ctrl.sv
sim/aes_ctrl_checker.sv
sim/tb_aes_ciph_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the round controller testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_aes_ciph_ctrl \
  -Mdir obj_dir \
  -f src.f

./obj_dir/Vtb_aes_ciph_ctrl | tee "$LOG"

if grep -q "Test FAILED" "$LOG"; then
  echo "Simulation failed, see $LOG"
  exit 1
fi

echo "Simulation passed"

// ==== sim/tb_aes_ciph_ctrl.sv ====
// Round controller testbench
`timescale 1ns/100ps

module tb_aes_ciph_ctrl;
  import aes_ctrl_pkg::*;

  localparam int ClkPeriod    = 8;
  localparam int NumBlocks    = 24;
  localparam int NumClears    = 12;
  localparam int NumErrTrials = 10;
  localparam int BlockTimeout = 64;  // Longest stalled block in cycles
  localparam int NumSlots     = 2 * NumBlocks + NumClears + 2 * NumErrTrials + 2;
  localparam int WatchdogNs   = NumSlots * BlockTimeout * ClkPeriod;

  logic                   clk;
  logic                   rst_n;
  sp2v_e                  in_valid, out_ready;
  key_len_e               key_len;
  logic                   key_clear, data_out_clear, alert_fatal;
  logic                   in_ready, out_valid, state_we, alert;
  state_sel_e             state_sel;
  add_rk_sel_e            add_rk_sel;
  logic [RndCtrWidth-1:0] rnd_ctr;
  logic                   key_clear_pulse, data_out_clear_pulse;
  int                     test_id;
  logic                   test_done;
  int                     errors, tests, tests_failed;
  int                     hs_fails;

  always #(ClkPeriod / 2) clk = ~clk;

  aes_ciph_ctrl #(
    .NumRails ( 2 )
  ) i_aes_ciph_ctrl (
    .clk_i            ( clk                  ),
    .rst_ni           ( rst_n                ),
    .in_valid_i       ( in_valid             ),
    .out_ready_i      ( out_ready            ),
    .key_len_i        ( key_len              ),
    .key_clear_i      ( key_clear            ),
    .data_out_clear_i ( data_out_clear       ),
    .alert_fatal_i    ( alert_fatal          ),
    .in_ready_o       ( in_ready             ),
    .out_valid_o      ( out_valid            ),
    .state_we_o       ( state_we             ),
    .state_sel_o      ( state_sel            ),
    .add_rk_sel_o     ( add_rk_sel           ),
    .rnd_ctr_o        ( rnd_ctr              ),
    .key_clear_o      ( key_clear_pulse      ),
    .data_out_clear_o ( data_out_clear_pulse ),
    .alert_o          ( alert                )
  );

  aes_ctrl_checker u_aes_ctrl_checker (
    .clk_i                  ( clk                  ),
    .rst_ni                 ( rst_n                ),
    .in_valid_i             ( in_valid             ),
    .out_ready_i            ( out_ready            ),
    .key_len_i              ( key_len              ),
    .key_clear_i            ( key_clear            ),
    .data_out_clear_i       ( data_out_clear       ),
    .alert_fatal_i          ( alert_fatal          ),
    .in_ready_i             ( in_ready             ),
    .out_valid_i            ( out_valid            ),
    .state_we_i             ( state_we             ),
    .state_sel_i            ( state_sel            ),
    .add_rk_sel_i           ( add_rk_sel           ),
    .rnd_ctr_i              ( rnd_ctr              ),
    .key_clear_pulse_i      ( key_clear_pulse      ),
    .data_out_clear_pulse_i ( data_out_clear_pulse ),
    .alert_i                ( alert                ),
    .test_id_i              ( test_id              ),
    .test_done_i            ( test_done            ),
    .errors_o               ( errors               ),
    .tests_o                ( tests                ),
    .tests_failed_o         ( tests_failed         )
  );

  ////////////////////
  // Stimulus tasks
  ////////////////////

  function automatic key_len_e pick_key_len();
    case ($urandom_range(0, 2))
      0:       return AES_128;
      1:       return AES_192;
      default: return AES_256;
    endcase
  endfunction

  function automatic logic [2:0] bad_sp2v();
    logic [2:0] v;
    do begin
      v = 3'($urandom_range(0, 7));
    end while (v inside {SP2V_HIGH, SP2V_LOW});
    return v;
  endfunction

  function automatic logic [2:0] bad_key_len();
    logic [2:0] v;
    do begin
      v = 3'($urandom_range(0, 7));
    end while (v inside {AES_128, AES_192, AES_256});
    return v;
  endfunction

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  // Closes the current test in the checker and returns mid-cycle
  task automatic end_test();
    @(posedge clk);
    test_done <= 1'b1;
    @(posedge clk);
    test_done <= 1'b0;
    @(negedge clk);
  endtask

  task automatic run_block(input bit stall);
    int cycles;
    bit xfer;
    @(posedge clk);
    in_valid  <= SP2V_HIGH;
    key_len   <= pick_key_len();
    out_ready <= stall ? SP2V_LOW : SP2V_HIGH;
    @(posedge clk);
    in_valid <= SP2V_LOW;
    cycles = 0;
    xfer   = 1'b0;
    while (!xfer && cycles < BlockTimeout) begin
      @(negedge clk);
      xfer = out_valid && (out_ready == SP2V_HIGH);  // Transfer at the coming edge
      @(posedge clk);
      cycles++;
      if (stall) out_ready <= ($urandom_range(0, 1) == 0) ? SP2V_HIGH : SP2V_LOW;
    end
    if (!xfer) begin
      $display("No result handshake within %0d cycles of the start", BlockTimeout);
      hs_fails++;
    end
  endtask

  task automatic run_clear();
    logic kc, dc;
    kc = 1'($urandom_range(0, 1));
    dc = kc ? 1'($urandom_range(0, 1)) : 1'b1;  // At least one request
    @(posedge clk);
    key_clear      <= kc;
    data_out_clear <= dc;
    in_valid       <= ($urandom_range(0, 1) == 1) ? SP2V_HIGH : SP2V_LOW;  // Competing start
    @(posedge clk);
    key_clear      <= 1'b0;
    data_out_clear <= 1'b0;
    in_valid       <= SP2V_LOW;
    repeat (2) @(posedge clk);  // CLEAR cycle, then the status pulse
  endtask

  task automatic run_error(input bit fatal);
    int sel;
    apply_reset();
    if ($urandom_range(0, 1) == 1) begin
      @(posedge clk);
      in_valid <= SP2V_HIGH;
      key_len  <= pick_key_len();
      @(posedge clk);
      in_valid <= SP2V_LOW;
    end
    repeat ($urandom_range(0, 16)) @(posedge clk);
    sel = fatal ? 3 : int'($urandom_range(0, 2));
    @(posedge clk);
    case (sel)
      0:       in_valid <= sp2v_e'(bad_sp2v());
      1:       out_ready <= sp2v_e'(bad_sp2v());
      2:       key_len <= key_len_e'(bad_key_len());
      default: alert_fatal <= 1'b1;
    endcase
    @(posedge clk);
    out_ready   <= SP2V_HIGH;
    key_len     <= AES_128;
    alert_fatal <= 1'b0;
    in_valid    <= SP2V_HIGH;  // Starts and clears are ignored from here on
    key_clear   <= 1'b1;
    repeat (6) @(posedge clk);
    in_valid  <= SP2V_LOW;
    key_clear <= 1'b0;
    @(posedge clk);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin : main
    void'($urandom(32'h006e_ab79));
    clk            = 1'b0;
    rst_n          = 1'b0;
    in_valid       = SP2V_LOW;
    out_ready      = SP2V_HIGH;
    key_len        = AES_128;
    key_clear      = 1'b0;
    data_out_clear = 1'b0;
    alert_fatal    = 1'b0;
    test_id        = 0;
    test_done      = 1'b0;
    hs_fails       = 0;

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk);
    end_test();

    test_id = 1;
    repeat (NumBlocks) run_block(1'b0);
    end_test();

    test_id = 2;
    repeat (NumBlocks) run_block(1'b1);
    end_test();

    test_id = 3;
    repeat (NumClears) run_clear();
    end_test();

    test_id = 4;
    repeat (NumErrTrials) run_error(1'b0);
    end_test();

    test_id = 5;
    repeat (NumErrTrials) run_error(1'b1);
    end_test();

    $display("Summary: %0d tests, %0d failed, %0d mismatches, %0d handshake timeouts",
             tests, tests_failed, errors, hs_fails);
    if (errors == 0 && tests_failed == 0 && hs_fails == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WatchdogNs);
    $display("Timeout: the tests did not complete within %0d ns", WatchdogNs);
    $display("Test FAILED");
    $finish;
  end

endmodule

// ==== sim/aes_ctrl_checker.sv ====
// Round controller reference model
`timescale 1ns/100ps

module aes_ctrl_checker (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  aes_ctrl_pkg::sp2v_e                  in_valid_i,
  input  aes_ctrl_pkg::sp2v_e                  out_ready_i,
  input  aes_ctrl_pkg::key_len_e               key_len_i,
  input  logic                                 key_clear_i,
  input  logic                                 data_out_clear_i,
  input  logic                                 alert_fatal_i,
  input  logic                                 in_ready_i,
  input  logic                                 out_valid_i,
  input  logic                                 state_we_i,
  input  aes_ctrl_pkg::state_sel_e             state_sel_i,
  input  aes_ctrl_pkg::add_rk_sel_e            add_rk_sel_i,
  input  logic [aes_ctrl_pkg::RndCtrWidth-1:0] rnd_ctr_i,
  input  logic                                 key_clear_pulse_i,
  input  logic                                 data_out_clear_pulse_i,
  input  logic                                 alert_i,
  input  int                                   test_id_i,
  input  logic                                 test_done_i,
  output int                                   errors_o,
  output int                                   tests_o,
  output int                                   tests_failed_o
);
  import aes_ctrl_pkg::*;

  ctrl_state_e            st;
  logic [RndCtrWidth-1:0] ctr;
  logic [RndCtrWidth-1:0] lim;
  logic                   kc_req, dc_req;
  logic                   kc_q, dc_q;   // Registered clear status
  int                     error_count = 0;
  int                     test_errors = 0;
  int                     tests_run = 0;
  int                     tests_failed = 0;

  assign errors_o       = error_count;
  assign tests_o        = tests_run;
  assign tests_failed_o = tests_failed;

  function automatic string test_label(input int id);
    case (id)
      0:       return "reset";
      1:       return "block";
      2:       return "backpressure";
      3:       return "clear";
      4:       return "bad_encoding";
      default: return "fatal_alert";
    endcase
  endfunction

  task automatic check_val(input string what, input logic [3:0] exp, input logic [3:0] act);
    if (exp !== act) begin
      $display("Error %s %s: expected %0h, actual %0h", test_label(test_id_i), what, exp, act);
      error_count++;
      test_errors++;
    end
  endtask

  ////////////////////
  // Compare and step
  ////////////////////

  always @(posedge clk_i) begin : model_step
    state_sel_e             exp_sel;
    add_rk_sel_e            exp_rk;
    logic                   enc_err;
    logic [RndCtrWidth-1:0] req_lim;

    if (!rst_ni) begin
      st     = IDLE;
      ctr    = '0;
      lim    = NumRounds128;
      kc_req = 1'b0;
      dc_req = 1'b0;
      kc_q   = 1'b0;
      dc_q   = 1'b0;
    end else begin
      // Outputs held during the cycle that this edge closes
      check_val("in_ready_o", 4'(st == IDLE), 4'(in_ready_i));
      check_val("out_valid_o", 4'(st == FINISH), 4'(out_valid_i));
      check_val("state_we_o", 4'(st == INIT || st == ROUND || st == CLEAR), 4'(state_we_i));
      check_val("alert_o", 4'(st == ERROR), 4'(alert_i));
      check_val("rnd_ctr_o", ctr, rnd_ctr_i);
      check_val("key_clear_o", 4'(kc_q), 4'(key_clear_pulse_i));
      check_val("data_out_clear_o", 4'(dc_q), 4'(data_out_clear_pulse_i));

      case (st)
        INIT:    exp_sel = STATE_INIT;
        CLEAR:   exp_sel = STATE_CLEAR;
        default: exp_sel = STATE_ROUND;
      endcase
      if (st == INIT) begin
        exp_rk = ADD_RK_INIT;
      end else if (ctr == lim) begin
        exp_rk = ADD_RK_FINAL;  // Last round
      end else begin
        exp_rk = ADD_RK_ROUND;
      end
      if (st == INIT || st == ROUND || st == CLEAR) begin
        check_val("state_sel_o", 4'(exp_sel), 4'(state_sel_i));
      end
      if (st == INIT || st == ROUND) begin
        check_val("add_rk_sel_o", 4'(exp_rk), 4'(add_rk_sel_i));
      end

      // Decode the sparse inputs
      enc_err = 1'b0;
      req_lim = NumRounds128;
      case (key_len_i)
        AES_128: req_lim = NumRounds128;
        AES_192: req_lim = NumRounds192;
        AES_256: req_lim = NumRounds256;
        default: enc_err = 1'b1;
      endcase
      if (!(in_valid_i inside {SP2V_HIGH, SP2V_LOW})) enc_err = 1'b1;
      if (!(out_ready_i inside {SP2V_HIGH, SP2V_LOW})) enc_err = 1'b1;

      kc_q = (st == CLEAR) && kc_req;
      dc_q = (st == CLEAR) && dc_req;

      case (st)
        IDLE: begin
          if (key_clear_i || data_out_clear_i) begin
            st     = CLEAR;
            kc_req = key_clear_i;
            dc_req = data_out_clear_i;
          end else if (in_valid_i == SP2V_HIGH) begin
            st  = INIT;
            lim = req_lim;
            ctr = '0;
          end
        end
        INIT: begin
          st  = ROUND;
          ctr = 4'd1;
        end
        ROUND: begin
          if (ctr == lim) begin
            st = FINISH;
          end else begin
            ctr = ctr + 4'd1;
          end
        end
        FINISH: begin
          if (out_ready_i == SP2V_HIGH) begin
            st  = IDLE;
            ctr = '0;
          end
        end
        CLEAR:   st = IDLE;
        default: ctr = '0;  // ERROR holds until reset
      endcase
      if (enc_err || alert_fatal_i) begin
        st  = ERROR;
        ctr = '0;
      end
    end

    if (test_done_i) begin
      tests_run++;
      if (test_errors != 0) tests_failed++;
      $display("%s: %s, %0d mismatches", test_label(test_id_i),
               (test_errors == 0) ? "pass" : "fail", test_errors);
      test_errors = 0;
    end
  end

endmodule

// ==== hdl/aes_ciph_ctrl.sv ====
// AES cipher round controller
`timescale 1ns/100ps

module aes_ciph_ctrl #(
  parameter int unsigned NumRails = 2
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  aes_ctrl_pkg::sp2v_e                  in_valid_i,
  input  aes_ctrl_pkg::sp2v_e                  out_ready_i,
  input  aes_ctrl_pkg::key_len_e               key_len_i,
  input  logic                                 key_clear_i,
  input  logic                                 data_out_clear_i,
  input  logic                                 alert_fatal_i,
  output logic                                 in_ready_o,
  output logic                                 out_valid_o,
  output logic                                 state_we_o,
  output aes_ctrl_pkg::state_sel_e             state_sel_o,
  output aes_ctrl_pkg::add_rk_sel_e            add_rk_sel_o,
  output logic [aes_ctrl_pkg::RndCtrWidth-1:0] rnd_ctr_o,
  output logic                                 key_clear_o,
  output logic                                 data_out_clear_o,
  output logic                                 alert_o
);
  import aes_ctrl_pkg::*;

  // Decoded inputs
  logic                   in_valid;
  logic                   out_ready;
  logic [RndCtrWidth-1:0] num_rounds;
  logic                   sp_enc_err;
  logic                   mr_err;

  // Per-rail outputs
  logic        [NumRails-1:0]                  mr_in_ready;
  logic        [NumRails-1:0]                  mr_out_valid;
  logic        [NumRails-1:0]                  mr_state_we;
  logic        [NumRails-1:0]                  mr_alert;
  logic        [NumRails-1:0]                  mr_key_clear_d;
  logic        [NumRails-1:0]                  mr_data_out_clear_d;
  state_sel_e  [NumRails-1:0]                  mr_state_sel;
  add_rk_sel_e [NumRails-1:0]                  mr_add_rk_sel;
  logic        [NumRails-1:0][RndCtrWidth-1:0] mr_rnd_ctr;

  logic key_clear_d, key_clear_q;
  logic data_out_clear_d, data_out_clear_q;

  aes_sp2v_chk u_aes_sp2v_chk (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .in_valid_i   ( in_valid_i  ),
    .out_ready_i  ( out_ready_i ),
    .key_len_i    ( key_len_i   ),
    .in_valid_o   ( in_valid    ),
    .out_ready_o  ( out_ready   ),
    .num_rounds_o ( num_rounds  ),
    .sp_enc_err_o ( sp_enc_err  )
  );

  ////////////////////
  // Rails
  ////////////////////

  for (genvar i = 0; i < NumRails; i++) begin : gen_rail
    aes_ctrl_rail u_aes_ctrl_rail (
      .clk_i            ( clk_i                  ),
      .rst_ni           ( rst_ni                 ),
      .in_valid_i       ( in_valid               ),
      .out_ready_i      ( out_ready              ),
      .num_rounds_i     ( num_rounds             ),
      .key_clear_i      ( key_clear_i            ),
      .data_out_clear_i ( data_out_clear_i       ),
      .sp_enc_err_i     ( sp_enc_err             ),
      .mr_err_i         ( mr_err                 ),
      .alert_fatal_i    ( alert_fatal_i          ),
      .in_ready_o       ( mr_in_ready[i]         ), // OR
      .out_valid_o      ( mr_out_valid[i]        ), // OR
      .state_we_o       ( mr_state_we[i]         ), // OR
      .state_sel_o      ( mr_state_sel[i]        ), // OR and compare
      .add_rk_sel_o     ( mr_add_rk_sel[i]       ), // OR and compare
      .rnd_ctr_o        ( mr_rnd_ctr[i]          ), // OR and compare
      .key_clear_o      ( mr_key_clear_d[i]      ), // AND
      .data_out_clear_o ( mr_data_out_clear_d[i] ), // AND
      .alert_o          ( mr_alert[i]            )  // OR
    );
  end

  aes_rail_combine #(
    .NumRails ( NumRails )
  ) u_aes_rail_combine (
    .clk_i              ( clk_i               ),
    .rst_ni             ( rst_ni              ),
    .in_ready_i         ( mr_in_ready         ),
    .out_valid_i        ( mr_out_valid        ),
    .state_we_i         ( mr_state_we         ),
    .alert_i            ( mr_alert            ),
    .key_clear_i        ( mr_key_clear_d      ),
    .data_out_clear_i   ( mr_data_out_clear_d ),
    .state_sel_i        ( mr_state_sel        ),
    .add_rk_sel_i       ( mr_add_rk_sel       ),
    .rnd_ctr_i          ( mr_rnd_ctr          ),
    .in_ready_o         ( in_ready_o          ),
    .out_valid_o        ( out_valid_o         ),
    .state_we_o         ( state_we_o          ),
    .state_sel_o        ( state_sel_o         ),
    .add_rk_sel_o       ( add_rk_sel_o        ),
    .rnd_ctr_o          ( rnd_ctr_o           ),
    .alert_o            ( alert_o             ),
    .key_clear_d_o      ( key_clear_d         ),
    .data_out_clear_d_o ( data_out_clear_d    ),
    .mr_err_o           ( mr_err              )
  );

  // Clear status one cycle behind the CLEAR state
  always_ff @(posedge clk_i or negedge rst_ni) begin : status_regs
    if (!rst_ni) begin
      key_clear_q      <= 1'b0;
      data_out_clear_q <= 1'b0;
    end else begin
      key_clear_q      <= key_clear_d;
      data_out_clear_q <= data_out_clear_d;
    end
  end

  assign key_clear_o      = key_clear_q;
  assign data_out_clear_o = data_out_clear_q;

endmodule

// ==== hdl/aes_rail_combine.sv ====
// Rail merge and mismatch detection
`timescale 1ns/100ps

module aes_rail_combine #(
  parameter int unsigned NumRails = 2
) (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  logic [NumRails-1:0]                                 in_ready_i,
  input  logic [NumRails-1:0]                                 out_valid_i,
  input  logic [NumRails-1:0]                                 state_we_i,
  input  logic [NumRails-1:0]                                 alert_i,
  input  logic [NumRails-1:0]                                 key_clear_i,
  input  logic [NumRails-1:0]                                 data_out_clear_i,
  input  aes_ctrl_pkg::state_sel_e  [NumRails-1:0]            state_sel_i,
  input  aes_ctrl_pkg::add_rk_sel_e [NumRails-1:0]            add_rk_sel_i,
  input  logic [NumRails-1:0][aes_ctrl_pkg::RndCtrWidth-1:0]  rnd_ctr_i,
  output logic                                                in_ready_o,
  output logic                                                out_valid_o,
  output logic                                                state_we_o,
  output aes_ctrl_pkg::state_sel_e                            state_sel_o,
  output aes_ctrl_pkg::add_rk_sel_e                           add_rk_sel_o,
  output logic [aes_ctrl_pkg::RndCtrWidth-1:0]                rnd_ctr_o,
  output logic                                                alert_o,
  output logic                                                key_clear_d_o,
  output logic                                                data_out_clear_d_o,
  output logic                                                mr_err_o
);
  import aes_ctrl_pkg::*;

  // One rail is enough to raise a control bit
  assign in_ready_o  = |in_ready_i;
  assign out_valid_o = |out_valid_i;
  assign state_we_o  = |state_we_i;
  assign alert_o     = |alert_i;

  // Status only counts once every rail agrees
  assign key_clear_d_o      = &key_clear_i;
  assign data_out_clear_d_o = &data_out_clear_i;

  ////////////////////
  // Multi-bit merge
  ////////////////////

  // A disagreeing rail either yields an illegal code or fails the compare
  always_comb begin : combine_multi_bit
    state_sel_o  = state_sel_e'(3'b000);
    add_rk_sel_o = add_rk_sel_e'(3'b000);
    rnd_ctr_o    = '0;
    mr_err_o     = 1'b0;

    for (int i = 0; i < NumRails; i++) begin
      state_sel_o  = state_sel_e'(state_sel_o | state_sel_i[i]);
      add_rk_sel_o = add_rk_sel_e'(add_rk_sel_o | add_rk_sel_i[i]);
      rnd_ctr_o    = rnd_ctr_o | rnd_ctr_i[i];
    end

    for (int i = 0; i < NumRails; i++) begin
      if (state_sel_o  != state_sel_i[i]  ||
          add_rk_sel_o != add_rk_sel_i[i] ||
          rnd_ctr_o    != rnd_ctr_i[i]) begin
        mr_err_o = 1'b1;
      end
    end
  end

  // Rails share all inputs, so they never diverge without a fault
  a_rails_agree: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !mr_err_o
  );

endmodule

// ==== hdl/aes_ctrl_rail.sv ====
// Round control FSM, single rail
`timescale 1ns/100ps

module aes_ctrl_rail (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 in_valid_i,
  input  logic                                 out_ready_i,
  input  logic [aes_ctrl_pkg::RndCtrWidth-1:0] num_rounds_i,
  input  logic                                 key_clear_i,
  input  logic                                 data_out_clear_i,
  input  logic                                 sp_enc_err_i,
  input  logic                                 mr_err_i,
  input  logic                                 alert_fatal_i,
  output logic                                 in_ready_o,
  output logic                                 out_valid_o,
  output logic                                 state_we_o,
  output aes_ctrl_pkg::state_sel_e             state_sel_o,
  output aes_ctrl_pkg::add_rk_sel_e            add_rk_sel_o,
  output logic [aes_ctrl_pkg::RndCtrWidth-1:0] rnd_ctr_o,
  output logic                                 key_clear_o,
  output logic                                 data_out_clear_o,
  output logic                                 alert_o
);
  import aes_ctrl_pkg::*;

  ctrl_state_e            state_d, state_q;
  logic [RndCtrWidth-1:0] rnd_ctr_d, rnd_ctr_q;
  logic [RndCtrWidth-1:0] num_rounds_d, num_rounds_q;
  logic                   key_clear_req_d, key_clear_req_q;
  logic                   data_out_clear_req_d, data_out_clear_req_q;
  logic                   err;

  assign err = sp_enc_err_i | mr_err_i | alert_fatal_i;

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin : fsm_next
    state_d              = state_q;
    rnd_ctr_d            = rnd_ctr_q;
    num_rounds_d         = num_rounds_q;
    key_clear_req_d      = key_clear_req_q;
    data_out_clear_req_d = data_out_clear_req_q;

    case (state_q)
      IDLE: begin
        // Clear wins over a start in the same cycle
        if (key_clear_i || data_out_clear_i) begin
          state_d              = CLEAR;
          key_clear_req_d      = key_clear_i;
          data_out_clear_req_d = data_out_clear_i;
        end else if (in_valid_i) begin
          state_d      = INIT;
          num_rounds_d = num_rounds_i;
          rnd_ctr_d    = '0;
        end
      end
      INIT: begin
        state_d   = ROUND;
        rnd_ctr_d = RndCtrWidth'(1);
      end
      ROUND: begin
        if (rnd_ctr_q == num_rounds_q) begin
          state_d = FINISH; // Counter holds at the limit
        end else begin
          rnd_ctr_d = rnd_ctr_q + 1'b1;
        end
      end
      FINISH: begin
        if (out_ready_i) begin
          state_d   = IDLE;
          rnd_ctr_d = '0;
        end
      end
      CLEAR: begin
        state_d              = IDLE;
        key_clear_req_d      = 1'b0;
        data_out_clear_req_d = 1'b0;
      end
      ERROR:   rnd_ctr_d = '0; // Terminal
      default: state_d   = ERROR;
    endcase

    if (err) begin
      state_d   = ERROR;
      rnd_ctr_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : fsm_regs
    if (!rst_ni) begin
      state_q              <= IDLE;
      rnd_ctr_q            <= '0;
      num_rounds_q         <= NumRounds128;
      key_clear_req_q      <= 1'b0;
      data_out_clear_req_q <= 1'b0;
    end else begin
      state_q              <= state_d;
      rnd_ctr_q            <= rnd_ctr_d;
      num_rounds_q         <= num_rounds_d;
      key_clear_req_q      <= key_clear_req_d;
      data_out_clear_req_q <= data_out_clear_req_d;
    end
  end

  ////////////////////
  // Moore outputs
  ////////////////////

  always_comb begin : fsm_out
    in_ready_o       = 1'b0;
    out_valid_o      = 1'b0;
    state_we_o       = 1'b0;
    state_sel_o      = STATE_ROUND;
    add_rk_sel_o     = ADD_RK_ROUND;
    key_clear_o      = 1'b0;
    data_out_clear_o = 1'b0;
    alert_o          = 1'b0;

    case (state_q)
      IDLE: in_ready_o = 1'b1;
      INIT: begin
        state_sel_o  = STATE_INIT;
        add_rk_sel_o = ADD_RK_INIT;
        state_we_o   = 1'b1;
      end
      ROUND: begin
        state_we_o   = 1'b1;
        add_rk_sel_o = (rnd_ctr_q == num_rounds_q) ? ADD_RK_FINAL : ADD_RK_ROUND;
      end
      FINISH: out_valid_o = 1'b1;
      CLEAR: begin
        state_sel_o      = STATE_CLEAR;
        state_we_o       = 1'b1;
        key_clear_o      = key_clear_req_q;
        data_out_clear_o = data_out_clear_req_q;
      end
      default: alert_o = 1'b1; // ERROR and unused codes
    endcase
  end

  assign rnd_ctr_o = rnd_ctr_q;

  a_rnd_ctr_limit: assert property (
    @(posedge clk_i) disable iff (!rst_ni) rnd_ctr_q <= num_rounds_q
  );

  a_error_terminal: assert property (
    @(posedge clk_i) disable iff (!rst_ni) state_q == ERROR |=> state_q == ERROR
  );

endmodule

// ==== hdl/aes_sp2v_chk.sv ====
// Sparse input decoder and checker
`timescale 1ns/100ps

module aes_sp2v_chk (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  aes_ctrl_pkg::sp2v_e                 in_valid_i,
  input  aes_ctrl_pkg::sp2v_e                 out_ready_i,
  input  aes_ctrl_pkg::key_len_e              key_len_i,
  output logic                                in_valid_o,
  output logic                                out_ready_o,
  output logic [aes_ctrl_pkg::RndCtrWidth-1:0] num_rounds_o,
  output logic                                sp_enc_err_o
);
  import aes_ctrl_pkg::*;

  logic in_valid_err;
  logic out_ready_err;
  logic key_len_err;

  // Only SP2V_HIGH counts as asserted
  assign in_valid_o  = (in_valid_i == SP2V_HIGH);
  assign out_ready_o = (out_ready_i == SP2V_HIGH);

  assign in_valid_err  = !(in_valid_i inside {SP2V_HIGH, SP2V_LOW});
  assign out_ready_err = !(out_ready_i inside {SP2V_HIGH, SP2V_LOW});

  // Round limit from key length
  always_comb begin : key_len_dec
    key_len_err  = 1'b0;
    num_rounds_o = NumRounds128;
    case (key_len_i)
      AES_128: num_rounds_o = NumRounds128;
      AES_192: num_rounds_o = NumRounds192;
      AES_256: num_rounds_o = NumRounds256;
      default: key_len_err  = 1'b1; // Safe limit until ERROR is taken
    endcase
  end

  assign sp_enc_err_o = in_valid_err | out_ready_err | key_len_err;

  // Error flag must resolve even when the inputs float
  a_sp_enc_err_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !$isunknown(sp_enc_err_o)
  );

endmodule

// ==== hdl/aes_ctrl_pkg.sv ====
// AES round controller definitions
package aes_ctrl_pkg;

  ////////////////////
  // Sparse inputs
  ////////////////////

  parameter int unsigned Sp2VWidth = 3;

  // Two legal codes, three bits apart
  typedef enum logic [Sp2VWidth-1:0] {
    SP2V_HIGH = 3'b011,
    SP2V_LOW  = 3'b100
  } sp2v_e;

  // One-hot key length with all other codes illegal
  typedef enum logic [2:0] {
    AES_128 = 3'b001,
    AES_192 = 3'b010,
    AES_256 = 3'b100
  } key_len_e;

  ////////////////////
  // Round counter
  ////////////////////

  parameter int unsigned RndCtrWidth = 4;

  parameter logic [RndCtrWidth-1:0] NumRounds128 = 4'd10;
  parameter logic [RndCtrWidth-1:0] NumRounds192 = 4'd12;
  parameter logic [RndCtrWidth-1:0] NumRounds256 = 4'd14;

  ////////////////////
  // FSM and selectors
  ////////////////////

  // Rail FSM with two unused codes treated as faults
  typedef enum logic [2:0] {
    IDLE   = 3'b000,
    INIT   = 3'b011,
    ROUND  = 3'b101,
    FINISH = 3'b110,
    CLEAR  = 3'b111,
    ERROR  = 3'b100
  } ctrl_state_e;

  // Pairwise Hamming distance 2
  typedef enum logic [2:0] {
    STATE_INIT  = 3'b011,
    STATE_ROUND = 3'b101,
    STATE_CLEAR = 3'b110
  } state_sel_e;

  typedef enum logic [2:0] {
    ADD_RK_INIT  = 3'b001,
    ADD_RK_ROUND = 3'b010,
    ADD_RK_FINAL = 3'b100
  } add_rk_sel_e;

endpackage
